/* hdl/ddr_port_pkg.sv */
package ddr_port_pkg;

	// User port word and byte address
	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;

	// One command always moves a full burst
	localparam int BURST_LEN   = 16;
	localparam int BURST_BYTES = BURST_LEN * (DATA_W / 8);
	localparam int BURST_CNT_W = $clog2(BURST_LEN + 1);

	// cmd_instr codes
	localparam logic [2:0] CMD_WRITE = 3'd0;
	localparam logic [2:0] CMD_READ  = 3'd1;

	// Model storage in words
	localparam int MEM_WORDS = 1024;
	// Word index taken from byte address bits 11..2
	localparam int WORD_LSB  = 2;
	localparam int WORD_W    = $clog2(MEM_WORDS);

	// Cycles after reset until the port reports calibration done
	localparam int CALIB_CYCLES = 40;

	// Write and read data FIFOs inside the port
	localparam int PORT_FIFO_DEPTH = 32;

endpackage

/* hdl/dma_ctrl_pkg.sv */
package dma_ctrl_pkg;

	// op_type value for blob reads
	// Anything else rereads the block at start_addr
	localparam logic [2:0] OP_BLOB = 3'd0;

	// Host input and output buffers
	localparam int IO_FIFO_DEPTH = 64;
	localparam int COUNT_W       = 7;

	// Engine FSM states
	localparam logic [3:0] ST_IDLE    = 4'd0;
	// Write path: pop a word, take it, check burst end
	localparam logic [3:0] ST_WR_POP  = 4'd1;
	localparam logic [3:0] ST_WR_TAKE = 4'd2;
	localparam logic [3:0] ST_WR_CMD  = 4'd3;
	// Read path, shared by blob and block reads
	localparam logic [3:0] ST_RD_CMD  = 4'd4;
	localparam logic [3:0] ST_RD_POP  = 4'd5;
	localparam logic [3:0] ST_RD_TAKE = 4'd6;
	localparam logic [3:0] ST_RD_NEXT = 4'd7;

endpackage

/* hdl/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo #(
	parameter int DEPTH = 16
) (
	input  logic                            clk,
	input  logic                            reset_d,
	input  logic                            push,
	input  logic [ddr_port_pkg::DATA_W-1:0] push_data,
	input  logic                            pop,
	output logic [ddr_port_pkg::DATA_W-1:0] pop_data,
	output logic                            pop_valid,
	output logic [$clog2(DEPTH+1)-1:0]      count,
	output logic                            empty,
	output logic                            full
);
	import ddr_port_pkg::*;

	// DEPTH is a power of two so the pointers wrap on their own
	localparam int PTR_W = $clog2(DEPTH);

	logic [DATA_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic              do_push;
	logic              do_pop;

	assign empty   = (count == '0);
	assign full    = (count == DEPTH);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_pop;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and registered read word
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_pop)
			pop_data <= mem[rd_ptr];
	end

endmodule

/* hdl/ddr_dma.sv */
`timescale 1ns/10ps

module ddr_dma (
	input  logic                             clk,
	input  logic                             reset_d,
	input  logic                             writes_en,
	input  logic                             reads_en,
	input  logic                             calib_done,
	input  logic [2:0]                       op_type,
	input  logic [ddr_port_pkg::ADDR_W-1:0]  start_addr,
	// Input buffer
	output logic                             ib_re,
	input  logic [ddr_port_pkg::DATA_W-1:0]  ib_data,
	input  logic [dma_ctrl_pkg::COUNT_W-1:0] ib_count,
	input  logic                             ib_valid,
	// Output buffer
	output logic                             ob_we,
	output logic [ddr_port_pkg::DATA_W-1:0]  ob_data,
	input  logic [dma_ctrl_pkg::COUNT_W-1:0] ob_count,
	// Memory port
	input  logic                             cmd_full,
	output logic                             cmd_en,
	output logic [2:0]                       cmd_instr,
	output logic [ddr_port_pkg::ADDR_W-1:0]  cmd_byte_addr,
	output logic                             wr_en,
	output logic [ddr_port_pkg::DATA_W-1:0]  wr_data,
	output logic                             rd_en,
	input  logic                             rd_empty,
	input  logic [ddr_port_pkg::DATA_W-1:0]  rd_data
);
	import ddr_port_pkg::*;
	import dma_ctrl_pkg::*;

	logic                   write_mode;
	logic                   read_mode;
	logic                   block_mode;
	logic [3:0]             curr_state;
	logic [3:0]             next_state;
	logic [BURST_CNT_W-1:0] burst_cnt;
	logic [ADDR_W-1:0]      wr_ptr;
	logic [ADDR_W-1:0]      rd_ptr;
	logic                   can_write;
	logic                   can_read;
	logic                   wr_issue;
	logic                   rd_issue;

	assign can_write = calib_done && write_mode && (ib_count >= BURST_LEN);
	// The word still in flight on ob_we counts as taken space
	assign can_read = calib_done && read_mode &&
		((ob_count + COUNT_W'(ob_we)) <= COUNT_W'(IO_FIFO_DEPTH - BURST_LEN));
	assign wr_issue = (curr_state == ST_WR_CMD) && (burst_cnt == '0) && !cmd_full;
	assign rd_issue = (curr_state == ST_RD_CMD) && !cmd_full;

	// Enables sampled once
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			write_mode <= 1'b0;
			read_mode  <= 1'b0;
		end else begin
			write_mode <= writes_en;
			read_mode  <= reads_en;
		end
	end

	always_comb begin
		next_state = curr_state;
		case (curr_state)
			ST_IDLE: begin
				// Writes win when both are ready
				if (can_write)
					next_state = ST_WR_POP;
				else if (can_read)
					next_state = ST_RD_CMD;
			end
			ST_WR_POP:  next_state = ST_WR_TAKE;
			ST_WR_TAKE: if (ib_valid) next_state = ST_WR_CMD;
			ST_WR_CMD: begin
				if (burst_cnt != '0)
					next_state = ST_WR_POP;
				else if (!cmd_full)
					next_state = ST_IDLE;
			end
			ST_RD_CMD:  if (!cmd_full) next_state = ST_RD_POP;
			ST_RD_POP:  if (!rd_empty) next_state = ST_RD_TAKE;
			ST_RD_TAKE: next_state = ST_RD_NEXT;
			ST_RD_NEXT: next_state = (burst_cnt == '0) ? ST_IDLE : ST_RD_POP;
			default:    next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			curr_state <= ST_IDLE;
			burst_cnt  <= '0;
			block_mode <= 1'b0;
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			ib_re      <= 1'b0;
			rd_en      <= 1'b0;
			wr_en      <= 1'b0;
			cmd_en     <= 1'b0;
			ob_we      <= 1'b0;
		end else begin
			curr_state <= next_state;
			// Strobes land in the state that needs them
			ib_re  <= (next_state == ST_WR_POP);
			rd_en  <= (next_state == ST_RD_TAKE);
			wr_en  <= (curr_state == ST_WR_TAKE) && ib_valid;
			ob_we  <= (curr_state == ST_RD_NEXT);
			cmd_en <= wr_issue || rd_issue;
			case (curr_state)
				ST_IDLE: begin
					burst_cnt  <= BURST_CNT_W'(BURST_LEN);
					block_mode <= (op_type != OP_BLOB);
					// Pointers follow start_addr only while fully stopped
					if (!write_mode && !read_mode) begin
						wr_ptr <= start_addr;
						rd_ptr <= start_addr;
					end
				end
				ST_WR_TAKE: if (ib_valid) burst_cnt <= burst_cnt - 1'b1;
				ST_WR_CMD:  if (wr_issue) wr_ptr <= wr_ptr + ADDR_W'(BURST_BYTES);
				ST_RD_CMD:  if (rd_issue && !block_mode) rd_ptr <= rd_ptr + ADDR_W'(BURST_BYTES);
				ST_RD_TAKE: burst_cnt <= burst_cnt - 1'b1;
				default:    ;
			endcase
		end
	end

	// Data and command payload
	always_ff @(posedge clk) begin
		if ((curr_state == ST_WR_TAKE) && ib_valid)
			wr_data <= ib_data;
		if (curr_state == ST_RD_NEXT)
			ob_data <= rd_data;
		if (wr_issue) begin
			cmd_instr     <= CMD_WRITE;
			cmd_byte_addr <= wr_ptr;
		end else if (rd_issue) begin
			cmd_instr     <= CMD_READ;
			cmd_byte_addr <= block_mode ? start_addr : rd_ptr;
		end
	end

endmodule

/* hdl/ddr_port_mem.sv */
`timescale 1ns/10ps

module ddr_port_mem (
	input  logic                            clk,
	input  logic                            reset_d,
	input  logic                            cmd_en,
	input  logic [2:0]                      cmd_instr,
	input  logic [ddr_port_pkg::ADDR_W-1:0] cmd_byte_addr,
	input  logic                            wr_en,
	input  logic [ddr_port_pkg::DATA_W-1:0] wr_data,
	input  logic                            rd_en,
	output logic                            calib_done,
	output logic                            cmd_full,
	output logic                            rd_empty,
	output logic [ddr_port_pkg::DATA_W-1:0] rd_data
);
	import ddr_port_pkg::*;

	logic [$clog2(CALIB_CYCLES)-1:0] cal_cnt;
	logic                            is_write;
	logic [BURST_CNT_W-1:0]          step;
	logic [WORD_W-1:0]               word_idx;
	logic [DATA_W-1:0]               mem [MEM_WORDS];
	logic                            in_burst;
	logic                            wf_pop;
	logic                            wf_valid;
	logic                            wf_empty;
	logic [DATA_W-1:0]               wf_data;
	logic                            rf_push;
	logic [DATA_W-1:0]               rf_data;

	// Transfers run during the first BURST_LEN busy cycles
	assign in_burst = cmd_full && (step < BURST_LEN);
	assign wf_pop   = in_burst && is_write && !wf_empty;
	assign rf_push  = in_burst && !is_write;
	assign rf_data  = mem[word_idx];

	// Calibration delay after reset
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			cal_cnt    <= '0;
			calib_done <= 1'b0;
		end else if (!calib_done) begin
			cal_cnt <= cal_cnt + 1'b1;
			if (cal_cnt == CALIB_CYCLES - 1)
				calib_done <= 1'b1;
		end
	end

	// Command execution, busy for BURST_LEN+1 cycles
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			cmd_full <= 1'b0;
			is_write <= 1'b0;
			step     <= '0;
			word_idx <= '0;
		end else if (!cmd_full && cmd_en) begin
			cmd_full <= 1'b1;
			is_write <= (cmd_instr == CMD_WRITE);
			step     <= '0;
			word_idx <= cmd_byte_addr[WORD_LSB +: WORD_W];
		end else if (cmd_full) begin
			if (step == BURST_LEN)
				cmd_full <= 1'b0;
			else
				step <= step + 1'b1;
			// Write data lags its pop by one cycle
			if (is_write ? wf_valid : rf_push)
				word_idx <= word_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_full && is_write && wf_valid)
			mem[word_idx] <= wf_data;
	end

	stream_fifo #(
		.DEPTH(PORT_FIFO_DEPTH)
	) i_wr_fifo (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (wr_en),
		.push_data (wr_data),
		.pop       (wf_pop),
		.pop_data  (wf_data),
		.pop_valid (wf_valid),
		.count     (),
		.empty     (wf_empty),
		.full      ()
	);

	stream_fifo #(
		.DEPTH(PORT_FIFO_DEPTH)
	) i_rd_fifo (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (rf_push),
		.push_data (rf_data),
		.pop       (rd_en),
		.pop_data  (rd_data),
		.pop_valid (),
		.count     (),
		.empty     (rd_empty),
		.full      ()
	);

endmodule

/* hdl/dma_subsystem.sv */
`timescale 1ns/10ps

module dma_subsystem (
	input  logic                            clk,
	input  logic                            reset_d,
	input  logic                            writes_en,
	input  logic                            reads_en,
	input  logic [2:0]                      op_type,
	input  logic [ddr_port_pkg::ADDR_W-1:0] start_addr,
	input  logic                            in_push,
	input  logic [ddr_port_pkg::DATA_W-1:0] in_data,
	input  logic                            out_pop,
	output logic                            in_full,
	output logic [ddr_port_pkg::DATA_W-1:0] out_data,
	output logic                            out_valid,
	output logic                            out_empty,
	output logic                            calib_done
);
	import ddr_port_pkg::*;
	import dma_ctrl_pkg::*;

	// Input buffer to engine
	logic               ib_re;
	logic               ib_valid;
	logic [DATA_W-1:0]  ib_data;
	logic [COUNT_W-1:0] ib_count;
	// Engine to output buffer
	logic               ob_we;
	logic [DATA_W-1:0]  ob_data;
	logic [COUNT_W-1:0] ob_count;
	// Engine to memory port
	logic               cmd_en;
	logic               cmd_full;
	logic [2:0]         cmd_instr;
	logic [ADDR_W-1:0]  cmd_byte_addr;
	logic               wr_en;
	logic [DATA_W-1:0]  wr_data;
	logic               rd_en;
	logic               rd_empty;
	logic [DATA_W-1:0]  rd_data;

	stream_fifo #(
		.DEPTH(IO_FIFO_DEPTH)
	) i_in_buf (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (in_push),
		.push_data (in_data),
		.pop       (ib_re),
		.pop_data  (ib_data),
		.pop_valid (ib_valid),
		.count     (ib_count),
		.empty     (),
		.full      (in_full)
	);

	stream_fifo #(
		.DEPTH(IO_FIFO_DEPTH)
	) i_out_buf (
		.clk       (clk),
		.reset_d   (reset_d),
		.push      (ob_we),
		.push_data (ob_data),
		.pop       (out_pop),
		.pop_data  (out_data),
		.pop_valid (out_valid),
		.count     (ob_count),
		.empty     (out_empty),
		.full      ()
	);

	// Port names match the nets above
	ddr_dma i_dma (.*);

	ddr_port_mem i_mem (.*);

endmodule

/* tests/tb_dma_subsystem.sv */
`timescale 1ns/10ps

module tb_dma_subsystem;
	import ddr_port_pkg::*;
	import dma_ctrl_pkg::*;

	localparam int          TIMEOUT_CYCLES = 6000;
	localparam logic [31:0] SEED           = 32'h73f1e3b6;

	logic              clk;
	logic              reset_d;
	logic              writes_en;
	logic              reads_en;
	logic [2:0]        op_type;
	logic [ADDR_W-1:0] start_addr;
	logic              in_push;
	logic [DATA_W-1:0] in_data;
	logic              out_pop;
	logic              in_full;
	logic [DATA_W-1:0] out_data;
	logic              out_valid;
	logic              out_empty;
	logic              calib_done;

	// Reference memory and the words the host should see next
	logic [DATA_W-1:0] ref_mem [MEM_WORDS];
	logic [DATA_W-1:0] exp_q [$];
	logic [DATA_W-1:0] exp_word;
	logic [DATA_W-1:0] got_word;
	logic              got_valid;
	logic              got_extra;
	logic              check_on;
	string             test_name;
	int                n_errors;
	int                n_checked;
	int                n_wr_cmds;
	int                cycle_cnt;

	dma_subsystem i_dma_subsystem (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Register each popped word next to the word it should equal
	always @(posedge clk) begin
		got_valid <= 1'b0;
		if (out_valid && check_on) begin
			got_valid <= 1'b1;
			got_word  <= out_data;
			got_extra <= (exp_q.size() == 0);
			if (exp_q.size() > 0)
				exp_word <= exp_q.pop_front();
			n_checked++;
		end
		if (i_dma_subsystem.cmd_en && i_dma_subsystem.cmd_instr == CMD_WRITE)
			n_wr_cmds++;
	end

	word_match: assert property (@(posedge clk) disable iff (reset_d)
		got_valid |-> got_word === exp_word)
		else begin
			n_errors++;
			$display("MISMATCH %s expected %08h actual %08h", test_name,
				$sampled(exp_word), $sampled(got_word));
		end

	no_extra_word: assert property (@(posedge clk) disable iff (reset_d)
		got_valid |-> !got_extra)
		else begin
			n_errors++;
			$display("%s: output buffer delivered a word that was never expected", test_name);
		end

	idle_after_reset: assert property (@(posedge clk)
		$fell(reset_d) |-> (out_empty && !out_valid && !calib_done && !in_full))
		else begin
			n_errors++;
			$display("Outputs were not idle right after reset");
		end

	// Nothing may leave the input buffer before the port is calibrated
	hold_until_calib: assert property (@(posedge clk) disable iff (reset_d)
		!calib_done |-> (!i_dma_subsystem.ib_re && !i_dma_subsystem.cmd_en))
		else begin
			n_errors++;
			$display("Engine moved data before calibration finished");
		end

	no_overflow: assert property (@(posedge clk) disable iff (reset_d)
		i_dma_subsystem.ob_we |-> !i_dma_subsystem.i_out_buf.full)
		else begin
			n_errors++;
			$display("%s: engine pushed into a full output buffer", test_name);
		end

	task automatic push_words(input int n, input int base_word);
		int          i;
		logic [31:0] w;
		i = 0;
		while (i < n) begin
			@(posedge clk);
			#1;
			in_push = !in_full;
			if (!in_full) begin
				w = $urandom();
				in_data = w;
				ref_mem[base_word + i] = w;
				i++;
			end
		end
		@(posedge clk);
		#1;
		in_push = 1'b0;
	endtask

	task automatic pop_words(input int n);
		int left;
		left = n;
		while (left > 0) begin
			@(posedge clk);
			#1;
			out_pop = !out_empty;
			if (!out_empty)
				left--;
		end
		@(posedge clk);
		#1;
		out_pop = 1'b0;
	endtask

	task automatic load_expected(input int base_word, input int n, input int reps);
		exp_q.delete();
		for (int r = 0; r < reps; r++)
			for (int i = 0; i < n; i++)
				exp_q.push_back(ref_mem[base_word + i]);
	endtask

	task automatic wait_checked(input int target);
		while (n_checked < target) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Drop both enables and let the current burst finish
	task automatic halt_engine();
		writes_en = 1'b0;
		reads_en  = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		while (i_dma_subsystem.i_dma.curr_state != ST_IDLE) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic flush_output();
		while (!out_empty) begin
			out_pop = 1'b1;
			@(posedge clk);
			#1;
		end
		out_pop = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic report_counts();
		$display("Compared %0d words, %0d errors", n_checked, n_errors);
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: run stopped after %0d cycles", cycle_cnt);
		report_counts();
		$display("Checks failed");
		$finish;
	end

	initial begin
		reset_d    = 1'b1;
		writes_en  = 1'b0;
		reads_en   = 1'b0;
		op_type    = 3'd0;
		start_addr = '0;
		in_push    = 1'b0;
		in_data    = '0;
		out_pop    = 1'b0;
		check_on   = 1'b0;
		n_errors   = 0;
		n_checked  = 0;
		n_wr_cmds  = 0;
		test_name  = "reset";
		void'($urandom(SEED));
		repeat (5) @(posedge clk);
		#1;
		reset_d = 1'b0;

		// Writes enabled while the port is still calibrating
		test_name = "blob_write";
		writes_en = 1'b1;
		push_words(64, 0);
		while (n_wr_cmds < 4) begin
			@(posedge clk);
			#1;
		end
		halt_engine();

		// Reads fill the output buffer with no pops, then it drains in order
		test_name = "blob_read";
		load_expected(0, 64, 1);
		check_on = 1'b1;
		reads_en = 1'b1;
		while (i_dma_subsystem.ob_count != IO_FIFO_DEPTH) begin
			@(posedge clk);
			#1;
		end
		halt_engine();
		pop_words(64);
		wait_checked(64);
		check_on = 1'b0;
		assert (out_empty)
			else begin
				n_errors++;
				$display("%s: output buffer still held words after the last expected one",
					test_name);
			end

		// Second burst read three times over
		test_name  = "block_read";
		op_type    = 3'd1;
		start_addr = ADDR_W'(64);
		load_expected(16, BURST_LEN, 3);
		check_on = 1'b1;
		reads_en = 1'b1;
		pop_words(48);
		wait_checked(112);
		check_on = 1'b0;
		halt_engine();
		flush_output();

		// Fresh burst at a new start address beats the pending read
		test_name  = "write_priority";
		op_type    = OP_BLOB;
		start_addr = ADDR_W'(128);
		repeat (2) @(posedge clk);
		#1;
		push_words(16, 32);
		load_expected(32, BURST_LEN, 1);
		check_on  = 1'b1;
		writes_en = 1'b1;
		reads_en  = 1'b1;
		pop_words(16);
		wait_checked(128);
		check_on = 1'b0;
		halt_engine();
		flush_output();

		report_counts();
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* sources.f */
hdl/ddr_port_pkg.sv
hdl/dma_ctrl_pkg.sv
hdl/stream_fifo.sv
hdl/ddr_dma.sv
hdl/ddr_port_mem.sv
hdl/dma_subsystem.sv
tests/tb_dma_subsystem.sv
